// File: source/microCorePkg.sv
`default_nettype none

package microCorePkg;

	typedef logic [7:0]  dataT;     // One data byte
	typedef logic [15:0] addrT;     // Bus address or program counter
	typedef logic [5:0]  uAddrT;    // Microcode address, doubles as flow index
	typedef logic [1:0]  useFieldT; // Where a micro-op takes its operand from

	// Codes 0..7 follow the Z80 3-bit register field
	typedef enum logic [3:0] {
		regB  = 4'd0,
		regC  = 4'd1,
		regD  = 4'd2,
		regE  = 4'd3,
		regH  = 4'd4,
		regL  = 4'd5,
		regHL = 4'd6, // Pair, the (HL) slot of the field
		regA  = 4'd7,
		regPC = 4'd8
	} regSelT;

	typedef enum logic [3:0] {
		nop   = 4'd0,
		sma   = 4'd1, // Latch address select
		srm   = 4'd2, // Register from read data
		smw   = 4'd3, // Memory write
		inc16 = 4'd4, // Register pair plus one
		aluOp = 4'd5, // LD, AND or XOR into a register
		rl    = 4'd6, // Rotate left through carry
		jcb   = 4'd7  // Continue with the CB table
	} uopCmdT;

	localparam useFieldT useUop = 2'd0; // Operand field of the micro-op
	localparam useFieldT useDst = 2'd1; // Opcode bits 5:3
	localparam useFieldT useSrc = 2'd2; // Opcode bits 2:0

	typedef struct packed {
		logic     incPc;
		logic     eof;       // Last word of a flow
		logic     latchInsn;
		uopCmdT   cmd;
		regSelT   operand;
		useFieldT useField;
	} uopT;

	typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} flowStateT;

	typedef struct packed {
		logic   enable;
		uopCmdT cmd;
		regSelT dstSel;
		regSelT srcSel;
		dataT   opcode;
		addrT   pc;
	} dpCtrlT;

	// ------------------------------------------------------------
	// Flow entry points in the microcode ROM
	localparam uAddrT flowFetch  = 6'd0;
	localparam uAddrT flowNop    = 6'd2;
	localparam uAddrT flowLdRn   = 6'd3;
	localparam uAddrT flowLdRr   = 6'd5;
	localparam uAddrT flowAlu    = 6'd6;
	localparam uAddrT flowStHl   = 6'd7;
	localparam uAddrT flowIncHl  = 6'd10;
	localparam uAddrT flowPrefix = 6'd11;
	localparam uAddrT flowRl     = 6'd13;

endpackage

`default_nettype wire

// File: source/dispatchLut.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchLut
(
	input  wire microCorePkg::dataT  opcode,
	output      microCorePkg::uAddrT flowIdx
);
	import microCorePkg::*;

	// Order matters, the narrow patterns come first
	always_comb
	begin
		casez (opcode)
			8'h76:      flowIdx = flowNop;    // HALT is not implemented
			8'b01110???: flowIdx = flowStHl;  // LD (HL),r
			8'b01???110: flowIdx = flowNop;   // LD r,(HL) left out
			8'b01??????: flowIdx = flowLdRr;  // LD r,r'
			8'b1010?110: flowIdx = flowNop;   // AND/XOR (HL) left out
			8'b1010????: flowIdx = flowAlu;   // AND r, XOR r
			8'h23:      flowIdx = flowIncHl;
			8'hcb:      flowIdx = flowPrefix;
			8'h36:      flowIdx = flowNop;    // LD (HL),n left out
			8'b00???110: flowIdx = flowLdRn;  // LD r,n
			default:    flowIdx = flowNop;
		endcase
	end

endmodule

`default_nettype wire

// File: source/prefixLut.sv
`timescale 1ns/1ns
`default_nettype none

module prefixLut
(
	input  wire microCorePkg::dataT  opcode,
	output      microCorePkg::uAddrT flowIdx
);
	import microCorePkg::*;

	// Second byte after CB
	always_comb
	begin
		casez (opcode)
			8'h16:      flowIdx = flowNop; // RL (HL) left out
			8'b00010???: flowIdx = flowRl;
			default:    flowIdx = flowNop;
		endcase
	end

endmodule

`default_nettype wire

// File: source/ucodeRom.sv
`timescale 1ns/1ns
`default_nettype none

module ucodeRom
(
	input  wire microCorePkg::uAddrT uAddr,
	output      microCorePkg::uopT   uop
);
	import microCorePkg::*;

	function automatic uopT word(input logic incPc, input logic eof, input logic latchInsn,
			input uopCmdT cmd, input regSelT operand, input useFieldT useField);
		word = {incPc, eof, latchInsn, cmd, operand, useField};
	endfunction

	always_comb
	begin
		case (uAddr)
			// ------------------------------------------------------------
			// Fetch
			flowFetch:          uop = word(1'b0, 1'b0, 1'b0, sma, regPC, useUop);
			flowFetch + 1'b1:   uop = word(1'b1, 1'b1, 1'b1, nop, regPC, useUop);
			flowNop:            uop = word(1'b0, 1'b1, 1'b0, nop, regPC, useUop);
			// LD r,n reads the byte after the opcode
			flowLdRn:           uop = word(1'b0, 1'b0, 1'b0, sma, regPC, useUop);
			flowLdRn + 1'b1:    uop = word(1'b1, 1'b1, 1'b0, srm, regPC, useDst);
			flowLdRr:           uop = word(1'b0, 1'b1, 1'b0, aluOp, regPC, useDst);
			flowAlu:            uop = word(1'b0, 1'b1, 1'b0, aluOp, regA, useUop);
			// ------------------------------------------------------------
			// Store through HL, then point the bus back at PC
			flowStHl:           uop = word(1'b0, 1'b0, 1'b0, sma, regHL, useUop);
			flowStHl + 6'd1:    uop = word(1'b0, 1'b0, 1'b0, smw, regPC, useSrc);
			flowStHl + 6'd2:    uop = word(1'b0, 1'b1, 1'b0, sma, regPC, useUop);
			flowIncHl:          uop = word(1'b0, 1'b1, 1'b0, inc16, regHL, useUop);
			// CB prefix fetches the second byte itself
			flowPrefix:         uop = word(1'b1, 1'b0, 1'b1, nop, regPC, useUop);
			flowPrefix + 1'b1:  uop = word(1'b0, 1'b1, 1'b0, jcb, regPC, useUop);
			flowRl:             uop = word(1'b0, 1'b1, 1'b0, rl, regPC, useSrc);
			default:            uop = word(1'b0, 1'b1, 1'b0, nop, regPC, useUop);
		endcase
	end

endmodule

`default_nettype wire

// File: source/uopSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module uopSequencer
#(
	parameter microCorePkg::addrT RESET_PC = 16'h0100
)
(
	input  wire                      iClock,
	input  wire                      arstN,
	input  wire microCorePkg::dataT  rdData,
	input  wire microCorePkg::uAddrT baseIdx,
	input  wire microCorePkg::uAddrT prefixIdx,
	input  wire microCorePkg::uopT   uop,
	output      microCorePkg::uAddrT uPc,
	output      microCorePkg::dataT  opcode,
	output      microCorePkg::dpCtrlT ctrl
);
	import microCorePkg::*;

	flowStateT state, nextState;
	addrT      pc;
	uAddrT     flowIdx;
	regSelT    dstSel;
	logic      fetchFlow; // Next flow to start is the fetch
	logic      cbPending; // Second byte of a CB opcode is waiting
	logic      isJcb;

	assign isJcb = (uop.cmd == jcb);

	always_comb
	begin
		if (fetchFlow)
			flowIdx = flowFetch;
		else if (cbPending)
			flowIdx = prefixIdx;
		else
			flowIdx = baseIdx;
	end

	// ------------------------------------------------------------
	// Flow state machine
	always_comb
	begin
		case (state)
			afterReset: nextState = startFlow;
			startFlow:  nextState = runFlow;
			runFlow:    nextState = uop.eof ? endFlow : runFlow;
			default:    nextState = startFlow;
		endcase
	end

	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= afterReset;
			uPc       <= flowFetch;
			pc        <= RESET_PC;
			opcode    <= '0;
			fetchFlow <= 1'b1;
			cbPending <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (state == startFlow)
			begin
				uPc <= flowIdx;
				if (!fetchFlow)
					cbPending <= 1'b0; // Consumed by this flow
			end
			if (state == runFlow)
			begin
				uPc <= uPc + 1'b1;
				if (uop.incPc)
					pc <= pc + 1'b1;
				if (uop.latchInsn)
					opcode <= rdData;
				if (isJcb)
					cbPending <= 1'b1;
				// Fetch goes to execute, execute back to fetch unless a prefix is pending
				if (uop.eof)
					fetchFlow <= !(fetchFlow || cbPending || isJcb);
			end
		end
	end

	// Operand selection against the latched opcode
	always_comb
	begin
		case (uop.useField)
			useDst:  dstSel = regSelT'({1'b0, opcode[5:3]});
			useSrc:  dstSel = regSelT'({1'b0, opcode[2:0]});
			default: dstSel = uop.operand;
		endcase
	end

	always_comb
	begin
		ctrl.enable = (state == runFlow);
		ctrl.cmd    = uop.cmd;
		ctrl.dstSel = dstSel;
		ctrl.srcSel = regSelT'({1'b0, opcode[2:0]}); // Source is always bits 2:0
		ctrl.opcode = opcode;
		ctrl.pc     = pc;
	end

endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath
(
	input  wire                       iClock,
	input  wire                       arstN,
	input  wire microCorePkg::dpCtrlT ctrl,
	input  wire microCorePkg::dataT   rdData,
	output      microCorePkg::addrT   addr,
	output      microCorePkg::dataT   dataOut,
	output logic                      we
);
	import microCorePkg::*;

	dataT   b, c, d, e, h, l, a;
	logic   carry;
	regSelT addrSel; // Latched by sma
	dataT   srcData;
	dataT   result;
	addrT   hl;
	addrT   hlNext;
	logic   regWe;
	logic   isLogic; // AND or XOR

	assign hl     = {h, l};
	assign hlNext = hl + 16'd1; // Wraps at 16 bits

	// ------------------------------------------------------------
	// Source read mux
	always_comb
	begin
		case (ctrl.srcSel)
			regB:    srcData = b;
			regC:    srcData = c;
			regD:    srcData = d;
			regE:    srcData = e;
			regH:    srcData = h;
			regL:    srcData = l;
			regA:    srcData = a;
			default: srcData = '0;
		endcase
	end

	assign isLogic = (ctrl.cmd == aluOp) && (ctrl.opcode[7:6] == 2'b10);

	// ALU, opcode bit 3 picks XOR over AND
	always_comb
	begin
		case (ctrl.cmd)
			srm:     result = rdData;
			aluOp:
			begin
				if (isLogic)
					result = ctrl.opcode[3] ? (a ^ srcData) : (a & srcData);
				else
					result = srcData; // LD r,r'
			end
			rl:      result = {srcData[6:0], carry};
			default: result = srcData;
		endcase
	end

	assign regWe = ctrl.enable &&
		(ctrl.cmd == srm || ctrl.cmd == aluOp || ctrl.cmd == rl);

	// ------------------------------------------------------------
	// Registers, carry and address select
	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
		begin
			b       <= '0;
			c       <= '0;
			d       <= '0;
			e       <= '0;
			h       <= '0;
			l       <= '0;
			a       <= '0;
			carry   <= 1'b0;
			addrSel <= regPC;
		end
		else
		begin
			if (regWe)
			begin
				case (ctrl.dstSel)
					regB:    b <= result;
					regC:    c <= result;
					regD:    d <= result;
					regE:    e <= result;
					regH:    h <= result;
					regL:    l <= result;
					regA:    a <= result;
					default: ; // Pair and PC take no byte result
				endcase
			end
			if (ctrl.enable && ctrl.cmd == inc16 && ctrl.dstSel == regHL)
				{h, l} <= hlNext;
			if (ctrl.enable && ctrl.cmd == sma)
				addrSel <= ctrl.dstSel;
			if (ctrl.enable && isLogic)
				carry <= 1'b0;
			else if (ctrl.enable && ctrl.cmd == rl)
				carry <= srcData[7]; // Old bit 7 out
		end
	end

	// Bus side
	assign addr    = (addrSel == regHL) ? hl : ctrl.pc;
	assign dataOut = srcData;
	assign we      = ctrl.enable && (ctrl.cmd == smw); // One micro-op, one cycle

endmodule

`default_nettype wire

// File: source/microCore.sv
`timescale 1ns/1ns
`default_nettype none

module microCore
#(
	parameter microCorePkg::addrT RESET_PC = 16'h0100
)
(
	input  wire                     iClock,
	input  wire                     arstN,
	input  wire microCorePkg::dataT rdData,
	output      microCorePkg::addrT addr,
	output      microCorePkg::dataT dataOut,
	output logic                    we
);
	import microCorePkg::*;

	dataT   opcode;
	uAddrT  baseIdx;
	uAddrT  prefixIdx;
	uAddrT  uPc;
	uopT    uop;
	dpCtrlT ctrl;

	// Both tables look at the latched opcode
	dispatchLut baseLut (.opcode(opcode), .flowIdx(baseIdx));

	prefixLut cbLut (.opcode(opcode), .flowIdx(prefixIdx));

	ucodeRom rom (.uAddr(uPc), .uop(uop));

	uopSequencer #(.RESET_PC(RESET_PC)) sequencer
	(
		.iClock(iClock),
		.arstN(arstN),
		.rdData(rdData),
		.baseIdx(baseIdx),
		.prefixIdx(prefixIdx),
		.uop(uop),
		.uPc(uPc),
		.opcode(opcode),
		.ctrl(ctrl)
	);

	datapath dp
	(
		.iClock(iClock),
		.arstN(arstN),
		.ctrl(ctrl),
		.rdData(rdData),
		.addr(addr),
		.dataOut(dataOut),
		.we(we)
	);

endmodule

`default_nettype wire

// File: verification/microCore_sva.sv
`timescale 1ns/1ns
`default_nettype none

module microCore_sva
(
	input wire                     iClock,
	input wire                     arstN,
	input wire microCorePkg::addrT addr,
	input wire                     we
);
	import microCorePkg::*;

	localparam addrT storeBase = 16'h8000; // Data area above the program

	weQuietInReset: assert property (@(posedge iClock) !arstN |-> !we)
		else $error("Write strobe high during reset");

	// Strobe is a single pulse
	weSingleCycle: assert property (@(posedge iClock) disable iff (!arstN) we |=> !we)
		else $error("Write strobe held longer than one cycle");

	storeInDataArea: assert property (@(posedge iClock) disable iff (!arstN)
		we |-> addr >= storeBase)
		else $error("Write to %h, below the data area", addr);

endmodule

bind microCore microCore_sva busChecks
(
	.iClock(iClock),
	.arstN(arstN),
	.addr(addr),
	.we(we)
);

`default_nettype wire

// File: verification/microCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module microCoreTb;
	import microCorePkg::*;

	localparam addrT resetPc     = 16'h0100;
	localparam int   numInsns    = 300;
	localparam int   clockPeriod = 20;
	localparam int   seed        = 22966;
	// A CB opcode is the longest at about 12 cycles
	localparam int   watchdogTime = (numInsns + 2) * 12 * clockPeriod + 100 * clockPeriod;

	logic iClock;
	logic arstN;
	dataT rdData;
	addrT addr;
	dataT dataOut;
	logic we;

	dataT mem [0:65535];
	addrT expAddr [$]; // Model stores in program order
	dataT expData [$];
	int   numWrites = 0;
	int   numExpected;

	microCore #(.RESET_PC(resetPc)) UUT
	(
		.iClock(iClock),
		.arstN(arstN),
		.rdData(rdData),
		.addr(addr),
		.dataOut(dataOut),
		.we(we)
	);

	assign rdData = mem[addr]; // Combinational read

	task automatic stopOnError();
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first error");
	endtask

	// Random register field code other than the (HL) slot
	function automatic logic [2:0] pickReg(input logic noH);
		logic [2:0] r;
		r = 3'($urandom_range(7));
		while (r == 3'd6 || (noH && r == 3'd4))
			r = 3'($urandom_range(7));
		return r;
	endfunction

	task automatic placeByte(inout addrT pc, input dataT value);
		mem[pc] = value;
		pc = pc + 16'd1;
	endtask

	// ------------------------------------------------------------
	// Random program at the reset address
	task automatic writeProgram();
		addrT       pc;
		logic [2:0] dst;
		logic [2:0] src;
		pc = resetPc;
		placeByte(pc, 8'h26); // LD H,80
		placeByte(pc, 8'h80);
		placeByte(pc, 8'h2e); // L near the top so INC HL carries into H
		placeByte(pc, 8'he0 | 8'($urandom_range(31)));
		repeat (numInsns)
		begin
			dst = pickReg(1'b1);
			src = pickReg(1'b0);
			case ($urandom_range(9))
				0: placeByte(pc, 8'h00);
				1:
				begin
					placeByte(pc, {2'b00, dst, 3'b110}); // LD r,n
					placeByte(pc, 8'($urandom));
				end
				2: placeByte(pc, {2'b01, dst, src});
				4: placeByte(pc, {5'b10100, src}); // AND
				5: placeByte(pc, {5'b10101, src}); // XOR
				6: placeByte(pc, 8'h23);
				7:
				begin
					placeByte(pc, 8'hcb);
					placeByte(pc, {5'b00010, dst}); // RL
				end
				default: placeByte(pc, {5'b01110, src}); // Stores weighted up
			endcase
		end
	endtask

	// ISA model that walks the program bytes and lists the stores
	task automatic runModel();
		dataT       regs [0:7];
		logic       carry;
		logic [8:0] rot;
		addrT       pc;
		addrT       hl;
		dataT       op;
		logic [2:0] dst;
		logic [2:0] src;
		regs = '{default: 8'h00};
		carry = 1'b0;
		pc = resetPc;
		repeat (numInsns + 2)
		begin
			op = mem[pc];
			pc = pc + 16'd1;
			dst = op[5:3];
			src = op[2:0];
			hl = {regs[4], regs[5]};
			if (op == 8'hcb)
			begin
				src = mem[pc][2:0];
				pc = pc + 16'd1;
				rot = {regs[src], carry};
				carry = rot[8];
				regs[src] = rot[7:0];
			end
			else if (op[7:6] == 2'b00 && src == 3'd6)
			begin
				regs[dst] = mem[pc];
				pc = pc + 16'd1;
			end
			else if (op == 8'h23)
			begin
				hl = hl + 16'd1;
				regs[4] = hl[15:8];
				regs[5] = hl[7:0];
			end
			else if (op[7:3] == 5'b01110)
			begin
				expAddr.push_back(hl);
				expData.push_back(regs[src]);
			end
			else if (op[7:6] == 2'b01)
				regs[dst] = regs[src];
			else if (op[7:4] == 4'b1010)
			begin
				regs[7] = op[3] ? (regs[7] ^ regs[src]) : (regs[7] & regs[src]);
				carry = 1'b0;
			end
		end
	endtask

	initial
	begin
		iClock = 1'b0;
		forever #(clockPeriod / 2) iClock = ~iClock;
	end

	// ------------------------------------------------------------
	// Memory side with each store checked against the model
	always @(posedge iClock)
	begin
		if (arstN && we)
		begin
			assert (numWrites < numExpected)
			else
			begin
				$display("ERROR at %0t: extra write %0d to %h", $time, numWrites + 1, addr);
				stopOnError();
			end
			assert (addr == expAddr[numWrites] && dataOut == expData[numWrites])
			else
			begin
				$display("ERROR at %0t: write %0d got %h <- %h, expected %h <- %h", $time,
					numWrites + 1, addr, dataOut, expAddr[numWrites], expData[numWrites]);
				stopOnError();
			end
			mem[addr] = dataOut;
			numWrites++;
		end
	end

	initial
	begin
		void'($urandom(seed));
		arstN = 1'b0;
		for (int i = 0; i < 65536; i++)
			mem[16'(i)] = 8'h00; // NOP
		writeProgram();
		runModel();
		numExpected = expAddr.size();
		repeat (4)
			@(posedge iClock);
		assert (addr == resetPc && we == 1'b0)
		else
		begin
			$display("ERROR at %0t: in reset addr %h we %b, expected %h and 0", $time,
				addr, we, resetPc);
			stopOnError();
		end
		#2 arstN = 1'b1;
		wait (numWrites == numExpected);
		repeat (100)
			@(posedge iClock); // Room for stray writes
		$display("NO ERRORS");
		$finish;
	end

	initial
	begin
		#(watchdogTime);
		$display("Timeout: the core made only %0d of %0d expected writes", numWrites,
			numExpected);
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog ended the run");
	end

endmodule

`default_nettype wire

// File: microCore.f
source/microCorePkg.sv
source/dispatchLut.sv
source/prefixLut.sv
source/ucodeRom.sv
source/uopSequencer.sv
source/datapath.sv
source/microCore.sv
verification/microCore_sva.sv
verification/microCoreTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the microCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module microCoreTb -f microCore.f \
	-o microCoreSim; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/microCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	echo "Test passed"
	exit 0
fi
echo "Test failed"
exit 1
